// File: hdl/pow5_macros.svh
// Fifth-power display subsystem, global sizing constants

`ifndef POW5_MACROS_SVH
`define POW5_MACROS_SVH

// --------------------
// Datapath
// --------------------

// Operand and product width, products wrap modulo 2**12
`define POW5_WIDTH 12

// Counter steps 0 .. 5 then wraps
`define POW5_MAX_OPERAND 5

// --------------------
// Display
// --------------------

`define POW5_DIGITS 4

`endif

// File: hdl/pow5_pkg.sv
// Fifth-power display subsystem, shared datapath and display types

`default_nettype none

`include "pow5_macros.svh"

package pow5_pkg;

    // Operand or partial product
    typedef logic [`POW5_WIDTH - 1:0] data_t;

    // --------------------
    // Pipeline payloads
    // --------------------

    // Operand plus the power computed so far
    typedef struct packed {
        data_t operand;
        data_t partial;
    } stage_t;

    // Operand plus its finished fifth power
    typedef struct packed {
        data_t operand;
        data_t power;
    } result_t;

    // Segment a at bit 7, dot h at bit 0
    typedef logic [7:0] segments_t;

endpackage

`default_nettype wire

// File: hdl/pow_stream_if.sv
// Result stream link with valid/ready handshake

`timescale 1ns/10ps
`default_nettype none

interface pow_stream_if
    import pow5_pkg::*;
();

    logic  vld;
    logic  rdy;
    data_t operand;
    data_t power;

    // Pipeline output side
    modport source (
        output vld,
        output operand,
        output power,
        input  rdy
    );

    // Display side
    modport sink (
        input  vld,
        input  operand,
        input  power,
        output rdy
    );

endinterface

`default_nettype wire

// File: hdl/operand_counter.sv
// Operand producer, wrapping counter offered on a valid/ready link

`timescale 1ns/10ps
`default_nettype none

`include "pow5_macros.svh"

module operand_counter
    import pow5_pkg::*;
(
    input  logic  slow_clk,
    input  logic  rst,
    input  logic  start,
    output logic  up_vld,
    input  logic  up_rdy,
    output data_t up_data
);

    data_t operand;
    logic  handshake;

    // Offer only while the key is held
    assign up_vld    = start;
    assign handshake = up_vld & up_rdy;

    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            operand <= '0;
        end else if (handshake) begin
            if (operand == data_t'(`POW5_MAX_OPERAND))
                operand <= '0;
            else
                operand <= operand + 1'b1;
        end
    end

    assign up_data = operand;

endmodule

`default_nettype wire

// File: hdl/pipe_stage.sv
// Single-entry valid/ready pipeline register for any payload type

`timescale 1ns/10ps
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     slow_clk,
    input  logic     rst,

    input  logic     in_vld,
    output logic     in_rdy,
    input  payload_t in_data,

    output logic     out_vld,
    input  logic     out_rdy,
    output payload_t out_data
);

    logic     full;
    payload_t item;

    // Room when empty or when the held item leaves this cycle
    assign in_rdy = ~full | out_rdy;

    // --------------------
    // Occupancy
    // --------------------

    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst)
            full <= 1'b0;
        else if (in_rdy)
            full <= in_vld;
    end

    // Payload register
    always_ff @(posedge slow_clk) begin
        if (in_vld & in_rdy)
            item <= in_data;
    end

    assign out_vld  = full;
    assign out_data = item;

endmodule

`default_nettype wire

// File: hdl/pow5_pipeline.sv
// Three-stage fifth-power pipeline, products modulo 2**12

`timescale 1ns/10ps
`default_nettype none

module pow5_pipeline
    import pow5_pkg::*;
(
    input  logic  slow_clk,
    input  logic  rst,

    input  logic  up_vld,
    output logic  up_rdy,
    input  data_t up_data,

    pow_stream_if.source down
);

    // Handshake between stages
    logic    s0_vld, s0_rdy;
    logic    s1_vld, s1_rdy;
    stage_t  s0_in, s0_out;
    stage_t  s1_in, s1_out;
    result_t s2_in, s2_out;

    // --------------------
    // Square
    // --------------------

    assign s0_in.operand = up_data;
    assign s0_in.partial = data_t'(up_data * up_data);

    pipe_stage #(.payload_t(stage_t)) stage_sq (
        .slow_clk (slow_clk), .rst     (rst),
        .in_vld   (up_vld),   .in_rdy  (up_rdy), .in_data  (s0_in),
        .out_vld  (s0_vld),   .out_rdy (s0_rdy), .out_data (s0_out)
    );

    // Fourth power from the square
    assign s1_in.operand = s0_out.operand;
    assign s1_in.partial = data_t'(s0_out.partial * s0_out.partial);

    pipe_stage #(.payload_t(stage_t)) stage_p4 (
        .slow_clk (slow_clk), .rst     (rst),
        .in_vld   (s0_vld),   .in_rdy  (s0_rdy), .in_data  (s1_in),
        .out_vld  (s1_vld),   .out_rdy (s1_rdy), .out_data (s1_out)
    );

    // --------------------
    // Fifth power
    // --------------------

    assign s2_in.operand = s1_out.operand;
    assign s2_in.power   = data_t'(s1_out.partial * s1_out.operand);

    pipe_stage #(.payload_t(result_t)) stage_p5 (
        .slow_clk (slow_clk), .rst     (rst),
        .in_vld   (s1_vld),   .in_rdy  (s1_rdy),   .in_data  (s2_in),
        .out_vld  (down.vld), .out_rdy (down.rdy), .out_data (s2_out)
    );

    assign down.operand = s2_out.operand;
    assign down.power   = s2_out.power;

endmodule

`default_nettype wire

// File: hdl/segment_scanner.sv
// Four-digit seven-segment scanner, consumes results on accept

`timescale 1ns/10ps
`default_nettype none

`include "pow5_macros.svh"

module segment_scanner
    import pow5_pkg::*;
(
    input  logic                      slow_clk,
    input  logic                      rst,
    input  logic                      accept,
    input  logic                      up_rdy,
    input  data_t                     next_operand,
    pow_stream_if.sink                up,
    output segments_t                 abcdefgh,
    output logic [`POW5_DIGITS - 1:0] digit
);

    localparam int scan_w = $clog2(`POW5_DIGITS);

    logic [scan_w - 1:0] scan;
    logic [3:0]          nibble;
    logic                blank;

    // Hex glyphs, dot always off
    function automatic segments_t hex_glyph(input logic [3:0] value);
        case (value)
            4'h0: hex_glyph = 8'b1111_1100;
            4'h1: hex_glyph = 8'b0110_0000;
            4'h2: hex_glyph = 8'b1101_1010;
            4'h3: hex_glyph = 8'b1111_0010;
            4'h4: hex_glyph = 8'b0110_0110;
            4'h5: hex_glyph = 8'b1011_0110;
            4'h6: hex_glyph = 8'b1011_1110;
            4'h7: hex_glyph = 8'b1110_0000;
            4'h8: hex_glyph = 8'b1111_1110;
            4'h9: hex_glyph = 8'b1111_0110;
            4'ha: hex_glyph = 8'b1110_1110;
            4'hb: hex_glyph = 8'b0011_1110;
            4'hc: hex_glyph = 8'b1001_1100;
            4'hd: hex_glyph = 8'b0111_1010;
            4'he: hex_glyph = 8'b1001_1110;
            default: hex_glyph = 8'b1000_1110;
        endcase
    endfunction

    // --------------------
    // Digit rotation
    // --------------------

    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst)
            scan <= '0;
        else
            scan <= scan + 1'b1;
    end

    assign digit = `POW5_DIGITS'(1) << scan;

    // Nibble and blanking for the selected digit
    always_comb begin
        case (scan)
            2'd0:    nibble = up.power[3:0];
            2'd1:    nibble = up.power[7:4];
            2'd2:    nibble = up.power[11:8];
            default: nibble = next_operand[3:0];
        endcase
        blank = (scan == 2'd3) ? ~up_rdy : ~up.vld;
    end

    assign abcdefgh = blank ? '0 : hex_glyph(nibble);

    // Key press takes the head result
    assign up.rdy = accept;

endmodule

`default_nettype wire

// File: hdl/pow5_display_top.sv
// Fifth-power demo top, counter into pipeline into display scanner

`timescale 1ns/10ps
`default_nettype none

`include "pow5_macros.svh"

module pow5_display_top
    import pow5_pkg::*;
(
    input  logic                      slow_clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic                      accept,
    output logic [7:0]                abcdefgh,
    output logic [`POW5_DIGITS - 1:0] digit,
    output logic [3:0]                led
);

    // Producer link
    logic  up_vld;
    logic  up_rdy;
    data_t up_data;

    pow_stream_if stream ();

    // --------------------
    // Blocks
    // --------------------

    operand_counter producer (
        .slow_clk (slow_clk),
        .rst      (rst),
        .start    (start),
        .up_vld   (up_vld),
        .up_rdy   (up_rdy),
        .up_data  (up_data)
    );

    pow5_pipeline pipeline (
        .slow_clk (slow_clk),
        .rst      (rst),
        .up_vld   (up_vld),
        .up_rdy   (up_rdy),
        .up_data  (up_data),
        .down     (stream.source)
    );

    segment_scanner scanner (
        .slow_clk     (slow_clk),
        .rst          (rst),
        .accept       (accept),
        .up_rdy       (up_rdy),
        .next_operand (up_data),
        .up           (stream.sink),
        .abcdefgh     (abcdefgh),
        .digit        (digit)
    );

    // Handshake status, upstream on the high bits
    assign led = {up_vld, up_rdy, stream.vld, stream.rdy};

endmodule

`default_nettype wire

// File: tests/pow5_display_properties.sv
// Handshake and scan assertions for the fifth-power display top

`timescale 1ns/10ps
`default_nettype none

`include "pow5_macros.svh"

module pow5_display_properties
    import pow5_pkg::*;
(
    input logic                      slow_clk,
    input logic                      rst,
    input logic                      down_vld,
    input logic                      down_rdy,
    input data_t                     down_operand,
    input data_t                     down_power,
    input logic [`POW5_DIGITS - 1:0] digit
);

    int unsigned failures = 0;

    // --------------------
    // Result stream
    // --------------------

    hold_valid: assert property (@(posedge slow_clk) disable iff (rst)
        down_vld && !down_rdy |=> down_vld)
    else begin
        $error("Result valid dropped before the result was taken");
        failures = failures + 1;
    end

    hold_data: assert property (@(posedge slow_clk) disable iff (rst)
        down_vld && !down_rdy |=> $stable(down_operand) && $stable(down_power))
    else begin
        $error("Result data changed while waiting for accept");
        failures = failures + 1;
    end

    // Empty pipeline right after reset
    idle_after_reset: assert property (@(posedge slow_clk) $fell(rst) |-> !down_vld)
    else begin
        $error("Result valid high in the first cycle after reset");
        failures = failures + 1;
    end

    scan_one_hot: assert property (@(posedge slow_clk) disable iff (rst) $onehot(digit))
    else begin
        $error("Digit select is not one-hot");
        failures = failures + 1;
    end

endmodule

`default_nettype wire

// File: tests/pow5_display_checker.sv
// Reference model that decodes the display and LEDs of the fifth-power demo

`timescale 1ns/10ps
`default_nettype none

`include "pow5_macros.svh"

module pow5_display_checker (
    input  logic                      slow_clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic                      accept,
    input  logic [7:0]                abcdefgh,
    input  logic [`POW5_DIGITS - 1:0] digit,
    input  logic [3:0]                led,
    output int                        error_count,
    output int                        result_count,
    output int                        in_flight
);

    // Segments a to g of each hex glyph
    localparam logic [6:0] glyphs [16] = '{
        7'b1111110, 7'b0110000, 7'b1101101, 7'b1111001,
        7'b0110011, 7'b1011011, 7'b1011111, 7'b1110000,
        7'b1111111, 7'b1111011, 7'b1110111, 7'b0011111,
        7'b1001110, 7'b0111101, 7'b1001111, 7'b1000111
    };

    int   next_operand;
    int   scan;
    int   pending [$];
    logic full [3];
    logic r0;
    logic r1;
    logic r2;

    function automatic int fifth_power(input int value);
        int acc;
        acc = 1;
        for (int n = 0; n < 5; n++)
            acc = (acc * value) % 4096;
        return acc;
    endfunction

    function automatic logic [7:0] glyph(input int value);
        return {glyphs[value[3:0]], 1'b0};
    endfunction

    task automatic mismatch(input string what, input int got, input int expected);
        error_count++;
        $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
                 $time, what, got, expected);
    endtask

    // Selected digit against the model
    task automatic check_segments;
        logic [7:0] expected;
        if (scan == 3)
            expected = r0 ? glyph(next_operand) : 8'h00;
        else if (full[2] && pending.size() > 0)
            expected = glyph(fifth_power(pending[0]) >> (4 * scan));
        else
            expected = 8'h00;
        if (abcdefgh !== expected)
            mismatch($sformatf("segments of digit %0d", scan), int'(abcdefgh), int'(expected));
    endtask

    // --------------------
    // Per-cycle compare and model update
    // --------------------

    always @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            next_operand = 0;
            scan         = 0;
            error_count  = 0;
            result_count = 0;
            in_flight    = 0;
            pending.delete();
            foreach (full[i])
                full[i] = 1'b0;
        end else begin
            r2 = !full[2] || accept;
            r1 = !full[1] || r2;
            r0 = !full[0] || r1;
            if (led[3] !== start)   mismatch("up valid LED", int'(led[3]), int'(start));
            if (led[2] !== r0)      mismatch("up ready LED", int'(led[2]), int'(r0));
            if (led[1] !== full[2]) mismatch("down valid LED", int'(led[1]), int'(full[2]));
            if (led[0] !== accept)  mismatch("down ready LED", int'(led[0]), int'(accept));
            if (digit !== (`POW5_DIGITS'(1) << scan))
                mismatch("digit select", int'(digit), 1 << scan);
            check_segments();
            if (led[1] && led[0]) begin
                if (pending.size() == 0) begin
                    error_count++;
                    $display("Result taken at %0t ns with no operand in flight", $time);
                end else begin
                    void'(pending.pop_front());
                    result_count++;
                end
            end
            if (led[3] && led[2]) begin
                pending.push_back(next_operand);
                next_operand = (next_operand == `POW5_MAX_OPERAND) ? 0 : next_operand + 1;
            end
            // Stages advance from the output end
            if (r2) full[2] = full[1];
            if (r1) full[1] = full[0];
            if (r0) full[0] = start;
            scan      = (scan + 1) % `POW5_DIGITS;
            in_flight = pending.size();
        end
    end

endmodule

`default_nettype wire

// File: tests/pow5_display_tb.sv
// Testbench for the fifth-power display with table-driven key stimulus

`timescale 1ns/10ps
`default_nettype none

`include "pow5_macros.svh"

module pow5_display_tb;

    localparam int period        = 8;
    localparam int reset_cycles  = 5;
    localparam int random_cycles = 200;
    localparam int margin_cycles = 64;
    localparam int num_steps     = 8;

    // Key levels held for a number of cycles
    typedef struct packed {
        logic start;
        logic accept;
        int   hold;
    } step_t;

    step_t steps [num_steps] = '{
        '{1'b0, 1'b0, 6},
        '{1'b1, 1'b1, 40},
        // Back-pressure fills all three stages
        '{1'b1, 1'b0, 12},
        '{1'b0, 1'b1, 8},
        '{1'b1, 1'b0, 3},
        '{1'b0, 1'b0, 4},
        '{1'b1, 1'b1, 20},
        '{1'b0, 1'b1, 6}
    };

    logic                      slow_clk;
    logic                      rst;
    logic                      start;
    logic                      accept;
    logic [7:0]                abcdefgh;
    logic [`POW5_DIGITS - 1:0] digit;
    logic [3:0]                led;
    int                        seed;
    int                        rnd;
    int                        error_count;
    int                        result_count;
    int                        in_flight;

    pow5_display_top dut0 (
        .slow_clk (slow_clk), .rst (rst), .start (start), .accept (accept),
        .abcdefgh (abcdefgh), .digit (digit), .led (led)
    );

    pow5_display_checker monitor0 (
        .slow_clk (slow_clk), .rst (rst), .start (start), .accept (accept),
        .abcdefgh (abcdefgh), .digit (digit), .led (led),
        .error_count (error_count), .result_count (result_count), .in_flight (in_flight)
    );

    bind pow5_display_top pow5_display_properties props0 (
        .slow_clk (slow_clk), .rst (rst), .down_vld (stream.vld), .down_rdy (stream.rdy),
        .down_operand (stream.operand), .down_power (stream.power), .digit (digit)
    );

    always #(period / 2) slow_clk = ~slow_clk;

    task automatic apply_step(input step_t step);
        start  = step.start;
        accept = step.accept;
        repeat (step.hold) @(negedge slow_clk);
    endtask

    task automatic report_verdict;
        int failures;
        failures = error_count + int'(dut0.props0.failures);
        if (result_count == 0)
            $display("No result was delivered during the run");
        $display("Errors: %0d check, %0d assertion; results delivered: %0d",
                 error_count, dut0.props0.failures, result_count);
        if (failures == 0 && result_count > 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    endtask

    // --------------------
    // Stimulus
    // --------------------

    initial begin
        slow_clk = 1'b0;
        rst      = 1'b1;
        start    = 1'b0;
        accept   = 1'b0;
        seed     = 32'h0d08_244d;
        repeat (reset_cycles) @(negedge slow_clk);
        rst = 1'b0;
        for (int i = 0; i < num_steps; i++)
            apply_step(steps[i]);
        repeat (random_cycles) begin
            rnd    = $random(seed);
            start  = rnd[0];
            accept = rnd[1];
            @(negedge slow_clk);
        end
        // Empty the pipeline before the verdict
        start  = 1'b0;
        accept = 1'b1;
        @(negedge slow_clk);
        while (in_flight != 0)
            @(negedge slow_clk);
        report_verdict();
    end

    // Watchdog sized from the stimulus length
    initial begin
        int cycles;
        cycles = reset_cycles + random_cycles + margin_cycles;
        foreach (steps[i])
            cycles += steps[i].hold;
        #(cycles * period);
        $display("Timeout: the run did not finish within %0d cycles", cycles);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: pow5_display.f
+incdir+hdl
hdl/pow5_pkg.sv
hdl/pow_stream_if.sv
hdl/operand_counter.sv
hdl/pipe_stage.sv
hdl/pow5_pipeline.sv
hdl/segment_scanner.sv
hdl/pow5_display_top.sv
tests/pow5_display_properties.sv
tests/pow5_display_checker.sv
tests/pow5_display_tb.sv

// File: Makefile
# Verilator build and run for the fifth-power display demo

VERILATOR ?= verilator
TOP       ?= pow5_display_tb
FILELIST  ?= pow5_display.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
RUN_FLAGS ?= +verilator+error+limit+1000
PASS_MSG  := *** PASSED ***

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard hdl/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_FLAGS))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

check: run

clean:
	rm -rf $(BUILD_DIR)
